//--- verilog/sd_cache_cfg_pkg.sv
package sd_cache_cfg_pkg;

    // Byte address into the card-side block memory
    localparam int ADDR_BITS = 16;

    // Word port
    localparam int WORD_BITS = 64;
    localparam int WORD_BYTES = WORD_BITS / 8;
    localparam int WORD_BYTES_LOG2 = 3;

    // A line is 32 bytes, which is also the width of the memory port
    localparam int LINE_BYTES_LOG2 = 5;
    localparam int LINE_BYTES = 1 << LINE_BYTES_LOG2;
    localparam int LINE_BITS = 8 * LINE_BYTES;
    localparam int WORDS_PER_LINE = LINE_BITS / WORD_BITS;

    // Tag is what remains of the address above index and line offset
    function automatic int tag_bits(int idx_bits);
        return ADDR_BITS - LINE_BYTES_LOG2 - idx_bits;
    endfunction

endpackage

//--- verilog/sd_cache_fsm_pkg.sv
package sd_cache_fsm_pkg;

    // Controller states
    typedef enum logic [3:0] {
        st_reset_sweep,
        st_idle,
        st_setup_read,
        st_check_hit,
        st_evaluate_miss,
        st_wait_grant,
        st_wait_data,
        st_install_line,
        st_write_bus,
        st_flush_addr,
        st_flush_check
    } sd_cache_state_e;

    // Per-line flag bits
    localparam int FL_VALID = 0;
    localparam int FL_DIRTY = 1;
    localparam int FL_BITS = 2;

endpackage

//--- verilog/sd_tag_mem.sv
`timescale 1ns/1ps

module sd_tag_mem #(
    parameter int IDX_BITS = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    input  logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  i_addr,
    input  logic [sd_cache_cfg_pkg::LINE_BYTES-1:0] i_wstrb,
    input  logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  i_wdata,
    input  logic [sd_cache_fsm_pkg::FL_BITS-1:0]    i_wflags,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  o_rdata,
    output logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  o_raddr,
    output logic [sd_cache_fsm_pkg::FL_BITS-1:0]    o_rflags,
    output logic                                    o_hit
);
    import sd_cache_cfg_pkg::*;
    import sd_cache_fsm_pkg::*;

    localparam int LINES = 1 << IDX_BITS;
    localparam int TAG_BITS = tag_bits(IDX_BITS);

    logic [LINE_BITS-1:0] data_mem [LINES];
    logic [TAG_BITS-1:0]  tag_mem  [LINES];
    logic [FL_BITS-1:0]   flag_mem [LINES];

    logic [IDX_BITS-1:0] addr_idx;
    logic [TAG_BITS-1:0] addr_tag;
    logic [IDX_BITS-1:0] rd_idx;
    logic [TAG_BITS-1:0] rd_tag;

    assign addr_idx = i_addr[LINE_BYTES_LOG2 +: IDX_BITS];
    assign addr_tag = i_addr[ADDR_BITS-1 -: TAG_BITS];

    // Read side registers the index and the tag it will compare against
    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            rd_idx <= '0;
            rd_tag <= '0;
        end else begin
            rd_idx <= addr_idx;
            rd_tag <= addr_tag;
        end
    end

    // Byte-strobed line write, tag and flags follow any strobe
    always_ff @(posedge i_clk) begin
        if (|i_wstrb) begin
            for (int i = 0; i < LINE_BYTES; i++) begin
                if (i_wstrb[i]) begin
                    data_mem[addr_idx][8*i +: 8] <= i_wdata[8*i +: 8];
                end
            end
            tag_mem[addr_idx] <= addr_tag;
            flag_mem[addr_idx] <= i_wflags;
        end
    end

    assign o_rdata = data_mem[rd_idx];
    assign o_rflags = flag_mem[rd_idx];

    // Line address of whatever is stored at this index
    assign o_raddr = {tag_mem[rd_idx], rd_idx, {LINE_BYTES_LOG2{1'b0}}};

    assign o_hit = flag_mem[rd_idx][FL_VALID] && (tag_mem[rd_idx] == rd_tag);

    // The controller must always present a known line address
    a_addr_known: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !$isunknown(i_addr))
        else $error("tag memory address is unknown");

endmodule

//--- verilog/sd_cache_ctrl.sv
`timescale 1ns/1ps

module sd_cache_ctrl #(
    parameter int IDX_BITS = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    input  logic                                    i_req_valid,
    input  logic                                    i_req_write,
    input  logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  i_req_addr,
    input  logic [sd_cache_cfg_pkg::WORD_BITS-1:0]  i_req_wdata,
    input  logic [sd_cache_cfg_pkg::WORD_BYTES-1:0] i_req_wstrb,
    output logic                                    o_req_ready,
    output logic                                    o_resp_valid,
    output logic [sd_cache_cfg_pkg::WORD_BITS-1:0]  o_resp_data,
    output logic                                    o_resp_err,
    input  logic                                    i_resp_ready,
    input  logic                                    i_req_mem_ready,
    output logic                                    o_req_mem_valid,
    output logic                                    o_req_mem_write,
    output logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  o_req_mem_addr,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  o_req_mem_data,
    input  logic                                    i_mem_data_valid,
    input  logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  i_mem_data,
    input  logic                                    i_mem_fault,
    input  logic                                    i_flush_valid,
    output logic                                    o_flush_end,
    output logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  o_line_addr,
    output logic [sd_cache_cfg_pkg::LINE_BYTES-1:0] o_line_wstrb,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  o_line_wdata,
    output logic [sd_cache_fsm_pkg::FL_BITS-1:0]    o_line_wflags,
    input  logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  i_line_rdata,
    input  logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  i_line_raddr,
    input  logic [sd_cache_fsm_pkg::FL_BITS-1:0]    i_line_rflags,
    input  logic                                    i_line_hit
);
    import sd_cache_cfg_pkg::*;
    import sd_cache_fsm_pkg::*;

    localparam int WSEL_BITS = LINE_BYTES_LOG2 - WORD_BYTES_LOG2;

    sd_cache_state_e      state;
    logic                 req_flush;
    logic                 req_mem_valid;
    logic                 req_mem_write;
    logic                 mem_fault;
    logic                 write_flush;
    logic [IDX_BITS-1:0]  sweep_cnt;
    logic [ADDR_BITS-1:0] line_addr;

    logic [ADDR_BITS-1:0]  req_addr;
    logic                  req_write;
    logic [WORD_BITS-1:0]  req_wdata;
    logic [WORD_BYTES-1:0] req_wstrb;
    logic [ADDR_BITS-1:0]  mem_addr;
    logic [LINE_BITS-1:0]  cache_line_o;
    logic [LINE_BITS-1:0]  cache_line_i;

    logic [WSEL_BITS-1:0]  ridx;
    logic [ADDR_BITS-1:0]  req_line;
    logic                  same_line;
    logic                  victim_dirty;
    logic                  sweep_last;
    logic                  accept;
    logic                  hit_taken;

    assign ridx = req_addr[LINE_BYTES_LOG2-1:WORD_BYTES_LOG2];
    assign req_line = {req_addr[ADDR_BITS-1:LINE_BYTES_LOG2], {LINE_BYTES_LOG2{1'b0}}};
    assign victim_dirty = i_line_rflags[FL_VALID] && i_line_rflags[FL_DIRTY];
    assign sweep_last = &sweep_cnt;
    assign accept = o_req_ready && i_req_valid;
    assign hit_taken = (state == st_check_hit) && i_line_hit && i_resp_ready;

    // Tag memory already holds this line's lookup, so setup can be skipped
    assign same_line = (i_req_addr[ADDR_BITS-1:LINE_BYTES_LOG2]
                        == line_addr[ADDR_BITS-1:LINE_BYTES_LOG2]);

    always_ff @(posedge i_clk or negedge i_nrst) begin
        if (!i_nrst) begin
            state <= st_reset_sweep;
            req_flush <= 1'b0;
            req_mem_valid <= 1'b0;
            req_mem_write <= 1'b0;
            mem_fault <= 1'b0;
            write_flush <= 1'b0;
            sweep_cnt <= '0;
            line_addr <= '0;
        end else begin
            if (i_flush_valid) begin
                req_flush <= 1'b1;
            end
            case (state)
                st_reset_sweep: begin
                    line_addr <= line_addr + ADDR_BITS'(LINE_BYTES);
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_last) begin
                        state <= st_idle;
                    end
                end
                st_idle: begin
                    mem_fault <= 1'b0;
                    if (req_flush) begin
                        req_flush <= i_flush_valid;
                        line_addr <= '0;
                        sweep_cnt <= '0;
                        state <= st_flush_addr;
                    end else if (i_req_valid) begin
                        line_addr <= i_req_addr;
                        state <= same_line ? st_check_hit : st_setup_read;
                    end
                end
                st_setup_read: state <= st_check_hit;
                st_check_hit: begin
                    if (!i_line_hit) begin
                        state <= st_evaluate_miss;
                    end else if (i_resp_ready) begin
                        state <= st_idle;
                    end
                end
                st_evaluate_miss: begin
                    // Dirty victim goes out before the new line is fetched
                    req_mem_valid <= 1'b1;
                    req_mem_write <= victim_dirty;
                    state <= st_wait_grant;
                end
                st_wait_grant: begin
                    if (i_req_mem_ready) begin
                        req_mem_valid <= 1'b0;
                        state <= req_mem_write ? st_write_bus : st_wait_data;
                    end
                end
                st_wait_data: begin
                    if (i_mem_data_valid) begin
                        mem_fault <= i_mem_fault;
                        state <= st_install_line;
                    end
                end
                st_install_line: begin
                    if (!mem_fault) begin
                        state <= st_setup_read;
                    end else if (i_resp_ready) begin
                        state <= st_idle;
                    end
                end
                st_write_bus: begin
                    if (i_mem_data_valid) begin
                        if (write_flush) begin
                            write_flush <= 1'b0;
                            state <= st_flush_check;
                        end else if (i_mem_fault) begin
                            // Failed write-back leaves the victim dirty
                            mem_fault <= 1'b1;
                            state <= st_install_line;
                        end else begin
                            req_mem_valid <= 1'b1;
                            req_mem_write <= 1'b0;
                            state <= st_wait_grant;
                        end
                    end
                end
                st_flush_addr: state <= st_flush_check;
                st_flush_check: begin
                    if (victim_dirty) begin
                        write_flush <= 1'b1;
                        req_mem_valid <= 1'b1;
                        req_mem_write <= 1'b1;
                        state <= st_wait_grant;
                    end else begin
                        line_addr <= line_addr + ADDR_BITS'(LINE_BYTES);
                        sweep_cnt <= sweep_cnt + 1'b1;
                        state <= sweep_last ? st_idle : st_flush_addr;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (accept) begin
            req_addr <= i_req_addr;
            req_write <= i_req_write;
            req_wdata <= i_req_wdata;
            req_wstrb <= i_req_wstrb;
        end
        if (state == st_evaluate_miss) begin
            mem_addr <= victim_dirty ? i_line_raddr : req_line;
            cache_line_o <= i_line_rdata;
        end
        if (state == st_flush_check) begin
            mem_addr <= i_line_raddr;
            cache_line_o <= i_line_rdata;
        end
        // Refill address once the victim has been written
        if (state == st_write_bus && i_mem_data_valid) begin
            mem_addr <= req_line;
        end
        if (state == st_wait_data && i_mem_data_valid) begin
            cache_line_i <= i_mem_data;
        end
    end

    always_comb begin
        o_line_wstrb = '0;
        o_line_wdata = '0;
        o_line_wflags = '0;
        o_resp_valid = 1'b0;
        o_resp_data = i_line_rdata[ridx*WORD_BITS +: WORD_BITS];
        o_flush_end = 1'b0;
        case (state)
            st_reset_sweep: o_line_wstrb = '1;
            st_check_hit: begin
                o_resp_valid = i_line_hit;
                // Write hit merges the strobed bytes of one word
                if (hit_taken && req_write) begin
                    o_line_wstrb = LINE_BYTES'(req_wstrb) << (ridx * WORD_BYTES);
                    o_line_wdata = {WORDS_PER_LINE{req_wdata}};
                    o_line_wflags[FL_VALID] = 1'b1;
                    o_line_wflags[FL_DIRTY] = 1'b1;
                end
            end
            st_install_line: begin
                o_resp_data = cache_line_i[ridx*WORD_BITS +: WORD_BITS];
                o_resp_valid = mem_fault;
                if (!mem_fault) begin
                    o_line_wstrb = '1;
                    o_line_wdata = cache_line_i;
                    o_line_wflags[FL_VALID] = 1'b1;
                end
            end
            st_write_bus: begin
                // Flushed line is cleaned as its write-back completes
                if (write_flush && i_mem_data_valid) begin
                    o_line_wstrb = '1;
                end
            end
            st_flush_check: begin
                if (!victim_dirty) begin
                    o_line_wstrb = '1;
                    o_flush_end = sweep_last;
                end
            end
            default: begin
            end
        endcase
    end

    assign o_req_ready = (state == st_idle) && !req_flush;
    assign o_resp_err = mem_fault;
    assign o_req_mem_valid = req_mem_valid;
    assign o_req_mem_write = req_mem_write;
    assign o_req_mem_addr = mem_addr;
    assign o_req_mem_data = cache_line_o;
    assign o_line_addr = line_addr;

    // Memory request holds until granted
    a_mem_req_hold: assert property (@(posedge i_clk) disable iff (!i_nrst)
        o_req_mem_valid && !i_req_mem_ready |=> o_req_mem_valid && $stable(o_req_mem_addr))
        else $error("memory request dropped or moved before grant");

    a_one_outstanding: assert property (@(posedge i_clk) disable iff (!i_nrst)
        !(o_resp_valid && o_req_ready))
        else $error("response pending while a new request is accepted");

endmodule

//--- verilog/sd_cache_top.sv
`timescale 1ns/1ps

module sd_cache_top #(
    parameter int IDX_BITS = 4
) (
    input  logic                                    i_clk,
    input  logic                                    i_nrst,
    input  logic                                    i_req_valid,
    input  logic                                    i_req_write,
    input  logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  i_req_addr,
    input  logic [sd_cache_cfg_pkg::WORD_BITS-1:0]  i_req_wdata,
    input  logic [sd_cache_cfg_pkg::WORD_BYTES-1:0] i_req_wstrb,
    output logic                                    o_req_ready,
    output logic                                    o_resp_valid,
    output logic [sd_cache_cfg_pkg::WORD_BITS-1:0]  o_resp_data,
    output logic                                    o_resp_err,
    input  logic                                    i_resp_ready,
    input  logic                                    i_req_mem_ready,
    output logic                                    o_req_mem_valid,
    output logic                                    o_req_mem_write,
    output logic [sd_cache_cfg_pkg::ADDR_BITS-1:0]  o_req_mem_addr,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  o_req_mem_data,
    input  logic                                    i_mem_data_valid,
    input  logic [sd_cache_cfg_pkg::LINE_BITS-1:0]  i_mem_data,
    input  logic                                    i_mem_fault,
    input  logic                                    i_flush_valid,
    output logic                                    o_flush_end
);
    import sd_cache_cfg_pkg::*;
    import sd_cache_fsm_pkg::*;

    // Controller to tag memory
    logic [ADDR_BITS-1:0]  line_addr;
    logic [LINE_BYTES-1:0] line_wstrb;
    logic [LINE_BITS-1:0]  line_wdata;
    logic [FL_BITS-1:0]    line_wflags;
    logic [LINE_BITS-1:0]  line_rdata;
    logic [ADDR_BITS-1:0]  line_raddr;
    logic [FL_BITS-1:0]    line_rflags;
    logic                  line_hit;

    sd_cache_ctrl #(
        .IDX_BITS(IDX_BITS)
    ) ctrl0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_req_valid(i_req_valid),
        .i_req_write(i_req_write),
        .i_req_addr(i_req_addr),
        .i_req_wdata(i_req_wdata),
        .i_req_wstrb(i_req_wstrb),
        .o_req_ready(o_req_ready),
        .o_resp_valid(o_resp_valid),
        .o_resp_data(o_resp_data),
        .o_resp_err(o_resp_err),
        .i_resp_ready(i_resp_ready),
        .i_req_mem_ready(i_req_mem_ready),
        .o_req_mem_valid(o_req_mem_valid),
        .o_req_mem_write(o_req_mem_write),
        .o_req_mem_addr(o_req_mem_addr),
        .o_req_mem_data(o_req_mem_data),
        .i_mem_data_valid(i_mem_data_valid),
        .i_mem_data(i_mem_data),
        .i_mem_fault(i_mem_fault),
        .i_flush_valid(i_flush_valid),
        .o_flush_end(o_flush_end),
        .o_line_addr(line_addr),
        .o_line_wstrb(line_wstrb),
        .o_line_wdata(line_wdata),
        .o_line_wflags(line_wflags),
        .i_line_rdata(line_rdata),
        .i_line_raddr(line_raddr),
        .i_line_rflags(line_rflags),
        .i_line_hit(line_hit)
    );

    sd_tag_mem #(
        .IDX_BITS(IDX_BITS)
    ) tag0 (
        .i_clk(i_clk),
        .i_nrst(i_nrst),
        .i_addr(line_addr),
        .i_wstrb(line_wstrb),
        .i_wdata(line_wdata),
        .i_wflags(line_wflags),
        .o_rdata(line_rdata),
        .o_raddr(line_raddr),
        .o_rflags(line_rflags),
        .o_hit(line_hit)
    );

endmodule

//--- verification/tb_clk_gen.sv
`timescale 1ns/1ps

module tb_clk_gen (
    output logic o_clk,
    output logic o_nrst
);
    // 4 ns period
    initial begin
        o_clk = 1'b0;
        forever #2 o_clk = ~o_clk;
    end

    // Reset held low over the first three rising edges
    initial begin
        o_nrst = 1'b0;
        repeat (3) @(posedge o_clk);
        @(negedge o_clk);
        o_nrst = 1'b1;
    end
endmodule

//--- verification/tb_sd_mem.sv
`timescale 1ns/1ps

module tb_sd_mem #(
    parameter int unsigned SEED = 25
) (
    input  logic                                   i_clk,
    input  logic                                   i_nrst,
    input  logic                                   i_req_valid,
    input  logic                                   i_req_write,
    input  logic [sd_cache_cfg_pkg::ADDR_BITS-1:0] i_req_addr,
    input  logic [sd_cache_cfg_pkg::LINE_BITS-1:0] i_req_data,
    output logic                                   o_req_ready,
    output logic                                   o_data_valid,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0] o_data,
    output logic                                   o_fault,
    output logic                                   o_wb_valid,
    output logic [sd_cache_cfg_pkg::ADDR_BITS-1:0] o_wb_addr,
    output logic [sd_cache_cfg_pkg::LINE_BITS-1:0] o_wb_data,
    output int                                     o_wb_count
);
    import sd_cache_cfg_pkg::*;

    logic [WORD_BITS-1:0] mem_w [8192];
    int unsigned          rng;
    int                   phase;
    int                   delay;
    int                   base;
    logic                 wr;
    logic [ADDR_BITS-1:0] addr;
    logic [LINE_BITS-1:0] wdata;

    function automatic int unsigned xorshift(int unsigned x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic roll_delay();
        rng = xorshift(rng);
        delay = int'(rng % 6);
    endtask

    // Each 16-bit lane holds the byte address of its word
    initial begin
        for (int i = 0; i < 8192; i++) begin
            mem_w[i] = {4{16'(i * 8)}};
        end
    end

    // Phase 0 waits, 1 delays the grant, 2 ends the grant, 3 delays completion
    initial begin
        rng = SEED;
        phase = 0;
        o_req_ready = 1'b0;
        o_data_valid = 1'b0;
        o_data = '0;
        o_fault = 1'b0;
        o_wb_valid = 1'b0;
        o_wb_addr = '0;
        o_wb_data = '0;
        o_wb_count = 0;
        forever begin
            @(negedge i_clk);
            o_data_valid = 1'b0;
            o_wb_valid = 1'b0;
            if (!i_nrst) begin
                phase = 0;
                o_req_ready = 1'b0;
            end else begin
                if (phase == 0 && i_req_valid) begin
                    roll_delay();
                    phase = 1;
                end
                if (phase == 1) begin
                    if (delay == 0) begin
                        o_req_ready = 1'b1;
                        wr = i_req_write;
                        addr = i_req_addr;
                        wdata = i_req_data;
                        phase = 2;
                    end else begin
                        delay--;
                    end
                end else if (phase == 2) begin
                    o_req_ready = 1'b0;
                    roll_delay();
                    phase = 3;
                end
                if (phase == 3) begin
                    if (delay == 0) begin
                        base = int'(addr >> 3);
                        o_fault = (addr >= 16'hF000);
                        o_data_valid = 1'b1;
                        o_data = {mem_w[base+3], mem_w[base+2], mem_w[base+1], mem_w[base]};
                        if (wr && !o_fault) begin
                            for (int k = 0; k < 4; k++) begin
                                mem_w[base+k] = wdata[64*k +: 64];
                            end
                            o_wb_valid = 1'b1;
                            o_wb_addr = addr;
                            o_wb_data = wdata;
                            o_wb_count++;
                        end
                        phase = 0;
                    end else begin
                        delay--;
                    end
                end
            end
        end
    end
endmodule

//--- verification/tb_sd_cache.sv
`timescale 1ns/1ps

module tb_sd_cache;
    import sd_cache_cfg_pkg::*;

    logic clk;
    logic nrst;
    logic req_valid;
    logic req_write;
    logic [ADDR_BITS-1:0] req_addr;
    logic [WORD_BITS-1:0] req_wdata;
    logic [7:0] req_wstrb;
    logic req_ready;
    logic resp_valid;
    logic [WORD_BITS-1:0] resp_data;
    logic resp_err;
    logic resp_ready;
    logic mem_ready;
    logic mem_valid;
    logic mem_write;
    logic [ADDR_BITS-1:0] mem_addr;
    logic [LINE_BITS-1:0] mem_wdata;
    logic mem_dvalid;
    logic [LINE_BITS-1:0] mem_rdata;
    logic mem_fault;
    logic flush_valid;
    logic flush_end;
    logic wb_valid;
    logic [ADDR_BITS-1:0] wb_addr;
    logic [LINE_BITS-1:0] wb_data;
    logic [LINE_BITS-1:0] wb_expect;
    int wb_count;

    logic [WORD_BITS-1:0] shadow_w [8192];
    logic [WORD_BITS-1:0] exp_data;
    logic exp_err;
    logic settling;
    logic flush_armed;
    int flush_count;
    int errors;
    int checks;
    int unsigned rng;

    tb_clk_gen clk0 (
        .o_clk(clk),
        .o_nrst(nrst)
    );

    tb_sd_mem #(
        .SEED(25)
    ) mem0 (
        .i_clk(clk),
        .i_nrst(nrst),
        .i_req_valid(mem_valid),
        .i_req_write(mem_write),
        .i_req_addr(mem_addr),
        .i_req_data(mem_wdata),
        .o_req_ready(mem_ready),
        .o_data_valid(mem_dvalid),
        .o_data(mem_rdata),
        .o_fault(mem_fault),
        .o_wb_valid(wb_valid),
        .o_wb_addr(wb_addr),
        .o_wb_data(wb_data),
        .o_wb_count(wb_count)
    );

    sd_cache_top #(
        .IDX_BITS(4)
    ) dut0 (
        .i_clk(clk),
        .i_nrst(nrst),
        .i_req_valid(req_valid),
        .i_req_write(req_write),
        .i_req_addr(req_addr),
        .i_req_wdata(req_wdata),
        .i_req_wstrb(req_wstrb),
        .o_req_ready(req_ready),
        .o_resp_valid(resp_valid),
        .o_resp_data(resp_data),
        .o_resp_err(resp_err),
        .i_resp_ready(resp_ready),
        .i_req_mem_ready(mem_ready),
        .o_req_mem_valid(mem_valid),
        .o_req_mem_write(mem_write),
        .o_req_mem_addr(mem_addr),
        .o_req_mem_data(mem_wdata),
        .i_mem_data_valid(mem_dvalid),
        .i_mem_data(mem_rdata),
        .i_mem_fault(mem_fault),
        .i_flush_valid(flush_valid),
        .o_flush_end(flush_end)
    );

    // Expected content of the line being written back
    assign wb_expect = {shadow_w[{wb_addr[15:5], 2'd3}], shadow_w[{wb_addr[15:5], 2'd2}],
                        shadow_w[{wb_addr[15:5], 2'd1}], shadow_w[{wb_addr[15:5], 2'd0}]};

    always @(posedge clk) begin
        if (flush_end) begin
            flush_count = flush_count + 1;
        end
    end

    a_quiet_after_reset: assert property (@(posedge clk) disable iff (!nrst)
        settling |-> !mem_valid && !resp_valid && !flush_end)
        else begin
            errors++;
            $display("error %0t: output active during the reset sweep", $time);
        end

    a_resp_value: assert property (@(posedge clk) disable iff (!nrst)
        resp_valid && resp_ready |-> resp_data == exp_data && resp_err == exp_err)
        else begin
            errors++;
            $display("error %0t: response %h err %b, expected %h err %b", $time,
                     $sampled(resp_data), $sampled(resp_err), exp_data, exp_err);
        end

    a_wb_line: assert property (@(posedge clk) disable iff (!nrst)
        wb_valid |-> wb_data == wb_expect)
        else begin
            errors++;
            $display("error %0t: written line at %h differs from expected", $time,
                     $sampled(wb_addr));
        end

    a_flush_expected: assert property (@(posedge clk) disable iff (!nrst)
        flush_end |-> flush_armed)
        else begin
            errors++;
            $display("error %0t: flush end pulse without a flush", $time);
        end

    function automatic int unsigned xorshift(int unsigned x);
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng = xorshift(rng);
        return rng;
    endfunction

    task automatic finish_run(input bit timed_out);
        $display("%0d responses checked, %0d errors", checks, errors);
        if (errors == 0 && !timed_out) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    endtask

    task automatic stop_on_timeout(input string what);
        $display("Gave up waiting for %s", what);
        finish_run(1'b1);
    endtask

    task automatic wait_ready();
        int t = 0;
        while (!req_ready && t < 500) begin
            @(negedge clk);
            t++;
        end
        if (!req_ready) begin
            stop_on_timeout("the request port to become ready");
        end
    endtask

    // One word access with the expected reply taken from the shadow before any merge
    task automatic access(input bit wr, input logic [15:0] addr, input logic [63:0] wdata,
                          input logic [7:0] strb, input bit err);
        int t = 0;
        bit taken = 1'b0;
        int w;
        w = int'(addr >> 3);
        wait_ready();
        exp_data = shadow_w[w];
        exp_err = err;
        req_valid = 1'b1;
        req_write = wr;
        req_addr = addr;
        req_wdata = wdata;
        req_wstrb = strb;
        @(negedge clk);
        req_valid = 1'b0;
        while (!taken && t < 300) begin
            resp_ready = (next_rand() % 4 != 0);
            taken = resp_valid && resp_ready;
            @(negedge clk);
            t++;
        end
        resp_ready = 1'b0;
        if (!taken) begin
            stop_on_timeout("a word response");
        end
        if (wr) begin
            for (int b = 0; b < 8; b++) begin
                if (strb[b]) begin
                    shadow_w[w][8*b +: 8] = wdata[8*b +: 8];
                end
            end
        end
        checks++;
    endtask

    task automatic flush_all();
        int base;
        int t = 0;
        wait_ready();
        base = flush_count;
        flush_armed = 1'b1;
        flush_valid = 1'b1;
        @(negedge clk);
        flush_valid = 1'b0;
        while (flush_count == base && t < 5000) begin
            @(negedge clk);
            t++;
        end
        if (flush_count == base) begin
            stop_on_timeout("the end of the flush");
        end
        wait_ready();
        flush_armed = 1'b0;
        a_one_flush_end: assert (flush_count == base + 1) else begin
            errors++;
            $display("error %0t: %0d flush end pulses", $time, flush_count - base);
        end
        // Backing store must now match every word
        for (int i = 0; i < 8192; i++) begin
            a_mem_match: assert (mem0.mem_w[i] == shadow_w[i]) else begin
                errors++;
                $display("error %0t: memory word %0d is %h, expected %h", $time, i,
                         mem0.mem_w[i], shadow_w[i]);
            end
        end
    endtask

    initial begin
        logic [15:0] a;
        logic [15:0] b;
        int t;
        int wb_before;
        req_valid = 1'b0;
        req_write = 1'b0;
        req_addr = '0;
        req_wdata = '0;
        req_wstrb = '0;
        resp_ready = 1'b0;
        flush_valid = 1'b0;
        flush_armed = 1'b0;
        flush_count = 0;
        settling = 1'b1;
        errors = 0;
        checks = 0;
        rng = 25;
        t = 0;
        for (int i = 0; i < 8192; i++) begin
            shadow_w[i] = {4{16'(i * 8)}};
        end

        while (!nrst && t < 20) begin
            @(negedge clk);
            t++;
        end
        if (!nrst) begin
            stop_on_timeout("reset release");
        end
        wait_ready();
        settling = 1'b0;

        // Reads that miss, then hit, then hit again in the same line
        for (int i = 0; i < 20; i++) begin
            a = 16'((next_rand() % 32'h1E00) * 8);
            access(1'b0, a, '0, '0, 1'b0);
            access(1'b0, a, '0, '0, 1'b0);
            access(1'b0, a ^ 16'h0008, '0, '0, 1'b0);
        end

        // Strobed writes each read back along with a neighbour in the same line
        for (int i = 0; i < 20; i++) begin
            a = 16'((next_rand() % 32'h1E00) * 8);
            access(1'b1, a, {next_rand(), next_rand()}, 8'(next_rand()), 1'b0);
            access(1'b0, a, '0, '0, 1'b0);
            access(1'b1, a ^ 16'h0010, {next_rand(), next_rand()}, 8'(next_rand()), 1'b0);
            access(1'b0, a ^ 16'h0010, '0, '0, 1'b0);
        end

        // Conflict on one index forces the dirty line out
        a = 16'h1208;
        b = a ^ 16'h0200;
        access(1'b1, a, {next_rand(), next_rand()}, 8'(next_rand()) | 8'h01, 1'b0);
        wb_before = wb_count;
        access(1'b0, b, '0, '0, 1'b0);
        a_evicted: assert (wb_count == wb_before + 1 && wb_addr == {a[15:5], 5'd0}) else begin
            errors++;
            $display("error %0t: dirty line %h was not written back", $time, a);
        end
        access(1'b0, a, '0, '0, 1'b0);

        for (int i = 0; i < 30; i++) begin
            a = 16'(next_rand()) & 16'h0FF8;
            access(1'b1, a, {next_rand(), next_rand()}, 8'(next_rand()), 1'b0);
        end
        flush_all();

        // Faulting region reads followed by a normal read that clears the error
        access(1'b0, 16'hF010, '0, '0, 1'b1);
        access(1'b0, 16'hFFF8, '0, '0, 1'b1);
        access(1'b0, 16'h0040, '0, '0, 1'b0);

        repeat (4) @(negedge clk);
        finish_run(1'b0);
    end
endmodule

//--- sd_cache_top.f
verilog/sd_cache_cfg_pkg.sv
verilog/sd_cache_fsm_pkg.sv
verilog/sd_tag_mem.sv
verilog/sd_cache_ctrl.sv
verilog/sd_cache_top.sv
verification/tb_clk_gen.sv
verification/tb_sd_mem.sv
verification/tb_sd_cache.sv

//--- Makefile
SRCS := $(wildcard verilog/*.sv verification/*.sv)

all: check

obj_dir/Vtb_sd_cache: sd_cache_top.f $(SRCS)
	verilator --binary --timing --assert -j 0 --top-module tb_sd_cache \
		-f sd_cache_top.f -o Vtb_sd_cache

sim.log: obj_dir/Vtb_sd_cache
	./obj_dir/Vtb_sd_cache > sim.log 2>&1 || true

run: sim.log
	cat sim.log

check: run
	@if grep -q "Test failed" sim.log; then exit 1; fi
	@grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run check clean
